/* logic/ctrl_pkg.sv */
//////////////////////////////////////////////////////////////////////
// encodings shared by the core controller blocks
// pc and operand selector values must match the fetch and id muxes
//////////////////////////////////////////////////////////////////////
`default_nettype none

package ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // pc source selection
  //////////////////////////////////////////////////////////////////////

  // selector sent to the fetch stage with pc_set
  typedef logic [2:0] pc_sel_t;

  localparam pc_sel_t PC_BOOT      = 3'b000;
  localparam pc_sel_t PC_JUMP      = 3'b010;
  localparam pc_sel_t PC_BRANCH    = 3'b011;
  localparam pc_sel_t PC_EXCEPTION = 3'b100;
  localparam pc_sel_t PC_ERET      = 3'b101;

  //////////////////////////////////////////////////////////////////////
  // operand forwarding
  //////////////////////////////////////////////////////////////////////

  // source of an operand in the id stage
  typedef logic [1:0] fw_sel_t;

  localparam fw_sel_t SEL_REGFILE = 2'b00;
  localparam fw_sel_t SEL_FW_EX   = 2'b01;
  localparam fw_sel_t SEL_FW_WB   = 2'b10;

  // jump class of the instruction in decode
  typedef logic [1:0] jump_kind_t;

  localparam jump_kind_t BRANCH_NONE = 2'b00;
  localparam jump_kind_t BRANCH_JAL  = 2'b01;
  localparam jump_kind_t BRANCH_JALR = 2'b10;
  localparam jump_kind_t BRANCH_COND = 2'b11;

  //////////////////////////////////////////////////////////////////////
  // controller states
  //////////////////////////////////////////////////////////////////////

  // flush runs ex then wb before sleep or decode
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_e;

endpackage

`default_nettype wire

/* logic/fwd_select.sv */
//////////////////////////////////////////////////////////////////////
// operand forwarding select, purely combinational
// register matches come precomputed from the decoder
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module fwd_select
  import ctrl_pkg::*;
(
  // pending writes
  input  logic    regfile_we_wb_i,
  input  logic    regfile_alu_we_fw_i,

  // destination matches per operand
  input  logic    reg_d_wb_is_reg_a_i,
  input  logic    reg_d_wb_is_reg_b_i,
  input  logic    reg_d_wb_is_reg_c_i,
  input  logic    reg_d_alu_is_reg_a_i,
  input  logic    reg_d_alu_is_reg_b_i,
  input  logic    reg_d_alu_is_reg_c_i,

  // overrides from lsu and multiplier
  input  logic    data_misaligned_i,
  input  logic    mult_multicycle_i,

  output fw_sel_t operand_a_fw_mux_sel_o,
  output fw_sel_t operand_b_fw_mux_sel_o,
  output fw_sel_t operand_c_fw_mux_sel_o
);

  // priority for one operand: alu forward over wb over regfile
  function automatic fw_sel_t pick_src(input logic wb_hit, input logic alu_hit);
    fw_sel_t sel;
    sel = SEL_REGFILE;
    if (wb_hit)
      sel = SEL_FW_WB;
    // youngest result wins
    if (alu_hit)
      sel = SEL_FW_EX;
    return sel;
  endfunction

  always_comb begin
    operand_a_fw_mux_sel_o = pick_src(regfile_we_wb_i & reg_d_wb_is_reg_a_i,
                                      regfile_alu_we_fw_i & reg_d_alu_is_reg_a_i);
    operand_b_fw_mux_sel_o = pick_src(regfile_we_wb_i & reg_d_wb_is_reg_b_i,
                                      regfile_alu_we_fw_i & reg_d_alu_is_reg_b_i);
    operand_c_fw_mux_sel_o = pick_src(regfile_we_wb_i & reg_d_wb_is_reg_c_i,
                                      regfile_alu_we_fw_i & reg_d_alu_is_reg_c_i);

    // second half of a misaligned access
    // a takes the address from ex, b back to regfile
    if (data_misaligned_i) begin
      operand_a_fw_mux_sel_o = SEL_FW_EX;
      operand_b_fw_mux_sel_o = SEL_REGFILE;
    end else if (mult_multicycle_i) begin
      // multiplier keeps its partial result on operand c
      operand_c_fw_mux_sel_o = SEL_FW_EX;
    end
  end

endmodule

`default_nettype wire

/* logic/hazard_detect.sv */
//////////////////////////////////////////////////////////////////////
// load-use and jump-register hazard detection
// stalls are raw, the fsm decides what they gate
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module hazard_detect
  import ctrl_pkg::*;
(
  // memory access in ex
  input  logic       data_req_ex_i,

  // pending writes per stage
  input  logic       regfile_we_ex_i,
  input  logic       regfile_we_wb_i,
  input  logic       regfile_alu_we_fw_i,

  // destination matches
  input  logic       reg_d_ex_is_reg_a_i,
  input  logic       reg_d_ex_is_reg_b_i,
  input  logic       reg_d_ex_is_reg_c_i,
  input  logic       reg_d_wb_is_reg_a_i,
  input  logic       reg_d_alu_is_reg_a_i,

  input  jump_kind_t jump_in_dec_i,

  output logic       load_stall_o,
  output logic       jr_stall_o
);

  logic ex_match_any;
  logic a_pending;

  // any operand reads the register the load in ex writes
  assign ex_match_any = reg_d_ex_is_reg_a_i | reg_d_ex_is_reg_b_i | reg_d_ex_is_reg_c_i;

  // load data only arrives in wb, too late for id
  assign load_stall_o = data_req_ex_i & regfile_we_ex_i & ex_match_any;

  // jalr target comes from operand a
  // the pc path has no forwarding, so wait for every pending write
  assign a_pending = (regfile_we_wb_i & reg_d_wb_is_reg_a_i) |
                     (regfile_we_ex_i & reg_d_ex_is_reg_a_i) |
                     (regfile_alu_we_fw_i & reg_d_alu_is_reg_a_i);

  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) & a_pending;

endmodule

`default_nettype wire

/* logic/pipe_ctrl_fsm.sv */
//////////////////////////////////////////////////////////////////////
// main control fsm: boot, sleep, decode and two-step flush
// outputs are combinational from inputs and state
// assumes the pipeline is flushed before sleep
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl_fsm
  import ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // start and wakeup
  input  logic       fetch_enable_i,

  // decoder status
  input  logic       illegal_insn_i,
  input  logic       eret_insn_i,
  input  logic       pipe_flush_i,
  input  logic       instr_valid_i,
  input  jump_kind_t jump_in_dec_i,

  // ex branch result
  input  logic       branch_taken_ex_i,

  // exception requests
  input  logic       exc_req_i,
  input  logic       ext_req_i,

  // pipeline progress
  input  logic       id_ready_i,
  input  logic       ex_valid_i,

  // hazards
  input  logic       load_stall_i,
  input  logic       jr_stall_i,

  output logic       ctrl_busy_o,
  output logic       is_decoding_o,
  output logic       deassert_we_o,
  output logic       instr_req_o,
  output logic       pc_set_o,
  output pc_sel_t    pc_mux_o,
  output logic       exc_ack_o,
  output logic       exc_save_if_o,
  output logic       exc_save_id_o,
  output logic       exc_save_takenbranch_o,
  output logic       exc_restore_id_o,
  output logic       halt_if_o,
  output logic       halt_id_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // set once a jump or eret has redirected fetch
  logic jump_done_q;
  logic jump_done_d;

  logic is_jump;

  assign is_jump = (jump_in_dec_i == BRANCH_JAL) | (jump_in_dec_i == BRANCH_JALR);

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d                = state_q;
    jump_done_d            = jump_done_q;

    ctrl_busy_o            = 1'b1;
    instr_req_o            = 1'b1;
    is_decoding_o          = 1'b0;

    pc_set_o               = 1'b0;
    pc_mux_o               = PC_BOOT;

    exc_ack_o              = 1'b0;
    exc_save_if_o          = 1'b0;
    exc_save_id_o          = 1'b0;
    exc_save_takenbranch_o = 1'b0;
    exc_restore_id_o       = 1'b0;

    halt_if_o              = 1'b0;
    halt_id_o              = 1'b0;

    case (state_q)
      // idle until fetch is enabled
      RESET: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load boot address into fetch, one cycle
      BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // pipeline empty, wait for enable or interrupt
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req_i)
          state_d = FIRST_FETCH;
      end

      // wait for the first instruction to reach id
      FIRST_FETCH: begin
        if (id_ready_i)
          state_d = DECODE;

        // interrupt that woke us up
        if (exc_req_i) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE: begin
        // a taken branch in ex kills the instruction in id
        if (instr_valid_i && !branch_taken_ex_i) begin
          is_decoding_o = 1'b1;

          if (is_jump) begin
            // target known in id, redirect once
            pc_mux_o = PC_JUMP;
            if (!jr_stall_i && !jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end else if (exc_req_i) begin
            // keep the faulting instruction out of ex
            pc_set_o      = 1'b1;
            pc_mux_o      = PC_EXCEPTION;
            exc_ack_o     = 1'b1;
            halt_id_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end

          if (eret_insn_i) begin
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
            if (!jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end

          // wfi, or eret back to sleep
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i)) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // nothing in id, external interrupt saves the if pc
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          halt_id_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end

        if (branch_taken_ex_i) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_BRANCH;
          is_decoding_o = 1'b0;
          // interrupt takes the branch target as return address
          if (ext_req_i) begin
            pc_mux_o               = PC_EXCEPTION;
            exc_ack_o              = 1'b1;
            halt_id_o              = 1'b1;
            exc_save_takenbranch_o = 1'b1;
          end
        end
      end

      // drain ex
      FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = FLUSH_WB;
      end

      // drain wb, then resume or sleep
      FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          halt_if_o = 1'b0;
          state_d   = DECODE;
        end else begin
          state_d = SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  // no register write for killed, illegal or stalled instructions
  assign deassert_we_o = ~is_decoding_o | illegal_insn_i | load_stall_i | jr_stall_i;

  //////////////////////////////////////////////////////////////////////
  // state registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // held while id is back-pressured
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

`default_nettype wire

/* logic/core_controller.sv */
//////////////////////////////////////////////////////////////////////
// core controller top: forwarding, hazards and control fsm
// register matches must be precomputed by the decoder
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module core_controller
  import ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       fetch_enable_i,
  output logic       ctrl_busy_o,
  output logic       is_decoding_o,

  // decoder
  output logic       deassert_we_o,
  input  logic       illegal_insn_i,
  input  logic       eret_insn_i,
  input  logic       pipe_flush_i,
  input  logic       instr_valid_i,
  input  jump_kind_t jump_in_dec_i,

  // fetch
  output logic       instr_req_o,
  output logic       pc_set_o,
  output pc_sel_t    pc_mux_o,

  // lsu, alu
  input  logic       data_req_ex_i,
  input  logic       data_misaligned_i,
  input  logic       mult_multicycle_i,
  input  logic       branch_taken_ex_i,

  // exceptions
  input  logic       exc_req_i,
  input  logic       ext_req_i,
  output logic       exc_ack_o,
  output logic       exc_save_if_o,
  output logic       exc_save_id_o,
  output logic       exc_save_takenbranch_o,
  output logic       exc_restore_id_o,

  // write enables of pending results
  input  logic       regfile_we_ex_i,
  input  logic       regfile_we_wb_i,
  input  logic       regfile_alu_we_fw_i,

  // destination matches
  input  logic       reg_d_ex_is_reg_a_i,
  input  logic       reg_d_ex_is_reg_b_i,
  input  logic       reg_d_ex_is_reg_c_i,
  input  logic       reg_d_wb_is_reg_a_i,
  input  logic       reg_d_wb_is_reg_b_i,
  input  logic       reg_d_wb_is_reg_c_i,
  input  logic       reg_d_alu_is_reg_a_i,
  input  logic       reg_d_alu_is_reg_b_i,
  input  logic       reg_d_alu_is_reg_c_i,

  output fw_sel_t    operand_a_fw_mux_sel_o,
  output fw_sel_t    operand_b_fw_mux_sel_o,
  output fw_sel_t    operand_c_fw_mux_sel_o,

  // stalls and halts
  output logic       halt_if_o,
  output logic       halt_id_o,
  output logic       jr_stall_o,
  output logic       load_stall_o,

  input  logic       id_ready_i,
  input  logic       ex_valid_i
);

  logic load_stall;
  logic jr_stall;

  assign load_stall_o = load_stall;
  assign jr_stall_o   = jr_stall;

  fwd_select i_fwd_select (
    .regfile_we_wb_i        (regfile_we_wb_i),
    .regfile_alu_we_fw_i    (regfile_alu_we_fw_i),
    .reg_d_wb_is_reg_a_i    (reg_d_wb_is_reg_a_i),
    .reg_d_wb_is_reg_b_i    (reg_d_wb_is_reg_b_i),
    .reg_d_wb_is_reg_c_i    (reg_d_wb_is_reg_c_i),
    .reg_d_alu_is_reg_a_i   (reg_d_alu_is_reg_a_i),
    .reg_d_alu_is_reg_b_i   (reg_d_alu_is_reg_b_i),
    .reg_d_alu_is_reg_c_i   (reg_d_alu_is_reg_c_i),
    .data_misaligned_i      (data_misaligned_i),
    .mult_multicycle_i      (mult_multicycle_i),
    .operand_a_fw_mux_sel_o (operand_a_fw_mux_sel_o),
    .operand_b_fw_mux_sel_o (operand_b_fw_mux_sel_o),
    .operand_c_fw_mux_sel_o (operand_c_fw_mux_sel_o)
  );

  hazard_detect i_hazard_detect (
    .data_req_ex_i        (data_req_ex_i),
    .regfile_we_ex_i      (regfile_we_ex_i),
    .regfile_we_wb_i      (regfile_we_wb_i),
    .regfile_alu_we_fw_i  (regfile_alu_we_fw_i),
    .reg_d_ex_is_reg_a_i  (reg_d_ex_is_reg_a_i),
    .reg_d_ex_is_reg_b_i  (reg_d_ex_is_reg_b_i),
    .reg_d_ex_is_reg_c_i  (reg_d_ex_is_reg_c_i),
    .reg_d_wb_is_reg_a_i  (reg_d_wb_is_reg_a_i),
    .reg_d_alu_is_reg_a_i (reg_d_alu_is_reg_a_i),
    .jump_in_dec_i        (jump_in_dec_i),
    .load_stall_o         (load_stall),
    .jr_stall_o           (jr_stall)
  );

  pipe_ctrl_fsm i_pipe_ctrl_fsm (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .fetch_enable_i         (fetch_enable_i),
    .illegal_insn_i         (illegal_insn_i),
    .eret_insn_i            (eret_insn_i),
    .pipe_flush_i           (pipe_flush_i),
    .instr_valid_i          (instr_valid_i),
    .jump_in_dec_i          (jump_in_dec_i),
    .branch_taken_ex_i      (branch_taken_ex_i),
    .exc_req_i              (exc_req_i),
    .ext_req_i              (ext_req_i),
    .id_ready_i             (id_ready_i),
    .ex_valid_i             (ex_valid_i),
    .load_stall_i           (load_stall),
    .jr_stall_i             (jr_stall),
    .ctrl_busy_o            (ctrl_busy_o),
    .is_decoding_o          (is_decoding_o),
    .deassert_we_o          (deassert_we_o),
    .instr_req_o            (instr_req_o),
    .pc_set_o               (pc_set_o),
    .pc_mux_o               (pc_mux_o),
    .exc_ack_o              (exc_ack_o),
    .exc_save_if_o          (exc_save_if_o),
    .exc_save_id_o          (exc_save_id_o),
    .exc_save_takenbranch_o (exc_save_takenbranch_o),
    .exc_restore_id_o       (exc_restore_id_o),
    .halt_if_o              (halt_if_o),
    .halt_id_o              (halt_id_o)
  );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
//////////////////////////////////////////////////////////////////////
// free-running 8 ns clock, reset low for the first 10 cycles
// reset is released on a falling edge
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    // release away from the rising edge
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* tb/tb_core_controller.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the core controller
// inputs change on the falling edge, outputs checked 1 ns later
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_core_controller
  import ctrl_pkg::*;
();

  localparam int RAND_CYCLES    = 300;
  // whole run is under 400 cycles
  localparam int TIMEOUT_CYCLES = 2000;

  logic       clk;
  logic       rst_n;

  // dut inputs
  logic       fetch_enable;
  logic       illegal_insn;
  logic       eret_insn;
  logic       pipe_flush;
  logic       instr_valid;
  jump_kind_t jump_in_dec;
  logic       data_req_ex;
  logic       data_misaligned;
  logic       mult_multicycle;
  logic       branch_taken_ex;
  logic       exc_req;
  logic       ext_req;
  logic       regfile_we_ex;
  logic       regfile_we_wb;
  logic       regfile_alu_we_fw;
  logic       reg_d_ex_is_reg_a;
  logic       reg_d_ex_is_reg_b;
  logic       reg_d_ex_is_reg_c;
  logic       reg_d_wb_is_reg_a;
  logic       reg_d_wb_is_reg_b;
  logic       reg_d_wb_is_reg_c;
  logic       reg_d_alu_is_reg_a;
  logic       reg_d_alu_is_reg_b;
  logic       reg_d_alu_is_reg_c;
  logic       id_ready;
  logic       ex_valid;

  // dut outputs
  logic       ctrl_busy_o;
  logic       is_decoding_o;
  logic       deassert_we_o;
  logic       instr_req_o;
  logic       pc_set_o;
  pc_sel_t    pc_mux_o;
  logic       exc_ack_o;
  logic       exc_save_if_o;
  logic       exc_save_id_o;
  logic       exc_save_takenbranch_o;
  logic       exc_restore_id_o;
  fw_sel_t    operand_a_fw_mux_sel_o;
  fw_sel_t    operand_b_fw_mux_sel_o;
  fw_sel_t    operand_c_fw_mux_sel_o;
  logic       halt_if_o;
  logic       halt_id_o;
  logic       jr_stall_o;
  logic       load_stall_o;

  logic [31:0] rng_state;
  int          cycle_count = 0;

  tb_clock_gen i_tb_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  core_controller i_core_controller (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .fetch_enable_i         (fetch_enable),
    .ctrl_busy_o            (ctrl_busy_o),
    .is_decoding_o          (is_decoding_o),
    .deassert_we_o          (deassert_we_o),
    .illegal_insn_i         (illegal_insn),
    .eret_insn_i            (eret_insn),
    .pipe_flush_i           (pipe_flush),
    .instr_valid_i          (instr_valid),
    .jump_in_dec_i          (jump_in_dec),
    .instr_req_o            (instr_req_o),
    .pc_set_o               (pc_set_o),
    .pc_mux_o               (pc_mux_o),
    .data_req_ex_i          (data_req_ex),
    .data_misaligned_i      (data_misaligned),
    .mult_multicycle_i      (mult_multicycle),
    .branch_taken_ex_i      (branch_taken_ex),
    .exc_req_i              (exc_req),
    .ext_req_i              (ext_req),
    .exc_ack_o              (exc_ack_o),
    .exc_save_if_o          (exc_save_if_o),
    .exc_save_id_o          (exc_save_id_o),
    .exc_save_takenbranch_o (exc_save_takenbranch_o),
    .exc_restore_id_o       (exc_restore_id_o),
    .regfile_we_ex_i        (regfile_we_ex),
    .regfile_we_wb_i        (regfile_we_wb),
    .regfile_alu_we_fw_i    (regfile_alu_we_fw),
    .reg_d_ex_is_reg_a_i    (reg_d_ex_is_reg_a),
    .reg_d_ex_is_reg_b_i    (reg_d_ex_is_reg_b),
    .reg_d_ex_is_reg_c_i    (reg_d_ex_is_reg_c),
    .reg_d_wb_is_reg_a_i    (reg_d_wb_is_reg_a),
    .reg_d_wb_is_reg_b_i    (reg_d_wb_is_reg_b),
    .reg_d_wb_is_reg_c_i    (reg_d_wb_is_reg_c),
    .reg_d_alu_is_reg_a_i   (reg_d_alu_is_reg_a),
    .reg_d_alu_is_reg_b_i   (reg_d_alu_is_reg_b),
    .reg_d_alu_is_reg_c_i   (reg_d_alu_is_reg_c),
    .operand_a_fw_mux_sel_o (operand_a_fw_mux_sel_o),
    .operand_b_fw_mux_sel_o (operand_b_fw_mux_sel_o),
    .operand_c_fw_mux_sel_o (operand_c_fw_mux_sel_o),
    .halt_if_o              (halt_if_o),
    .halt_id_o              (halt_id_o),
    .jr_stall_o             (jr_stall_o),
    .load_stall_o           (load_stall_o),
    .id_ready_i             (id_ready),
    .ex_valid_i             (ex_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // newest result first: alu forward, then wb, then regfile
  function automatic fw_sel_t fw_priority(input logic wb_hit, input logic alu_hit);
    return alu_hit ? SEL_FW_EX : (wb_hit ? SEL_FW_WB : SEL_REGFILE);
  endfunction

  task automatic expect_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic expect_code(input string name, input logic [2:0] got, input logic [2:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic step();
    @(negedge clk);
  endtask

  // everything but fetch_enable and id_ready back to idle
  task automatic quiet_pipeline();
    illegal_insn       = 1'b0;
    eret_insn          = 1'b0;
    pipe_flush         = 1'b0;
    instr_valid        = 1'b0;
    jump_in_dec        = BRANCH_NONE;
    data_req_ex        = 1'b0;
    data_misaligned    = 1'b0;
    mult_multicycle    = 1'b0;
    branch_taken_ex    = 1'b0;
    exc_req            = 1'b0;
    ext_req            = 1'b0;
    regfile_we_ex      = 1'b0;
    regfile_we_wb      = 1'b0;
    regfile_alu_we_fw  = 1'b0;
    reg_d_ex_is_reg_a  = 1'b0;
    reg_d_ex_is_reg_b  = 1'b0;
    reg_d_ex_is_reg_c  = 1'b0;
    reg_d_wb_is_reg_a  = 1'b0;
    reg_d_wb_is_reg_b  = 1'b0;
    reg_d_wb_is_reg_c  = 1'b0;
    reg_d_alu_is_reg_a = 1'b0;
    reg_d_alu_is_reg_b = 1'b0;
    reg_d_alu_is_reg_c = 1'b0;
    ex_valid           = 1'b0;
  endtask

  // flush drains into sleep, busy must drop within max_cycles
  task automatic wait_idle(input int max_cycles);
    int n;
    n = 0;
    #1;
    while (ctrl_busy_o && n < max_cycles) begin
      step();
      #1;
      n++;
    end
    if (ctrl_busy_o)
      report_failure("ctrl_busy_o stayed high after the pipeline flush");
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus and checks
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] word;
    logic [2:0]  boot_pulses;
    fw_sel_t     exp_a;
    fw_sel_t     exp_b;
    fw_sel_t     exp_c;
    logic        exp_load;
    logic        exp_jr;
    logic        exp_jump;

    rng_state    = 32'd14;
    boot_pulses  = 3'd0;
    fetch_enable = 1'b0;
    id_ready     = 1'b0;
    quiet_pipeline();

    // reset and boot
    wait (rst_n === 1'b1);
    #1;
    expect_bit("ctrl_busy_o", ctrl_busy_o, 1'b0);
    expect_bit("instr_req_o", instr_req_o, 1'b0);
    expect_bit("pc_set_o", pc_set_o, 1'b0);
    step();
    fetch_enable = 1'b1;
    // id held back, so the fsm parks in first fetch
    repeat (6) begin
      #1;
      if (pc_set_o) begin
        boot_pulses = boot_pulses + 3'd1;
        expect_code("pc_mux_o", pc_mux_o, PC_BOOT);
      end
      step();
    end
    expect_code("boot pc_set_o pulse count", boot_pulses, 3'd1);
    id_ready = 1'b1;
    #1;
    expect_bit("pc_set_o", pc_set_o, 1'b0);
    step();
    #1;
    expect_bit("pc_set_o", pc_set_o, 1'b0);
    expect_bit("ctrl_busy_o", ctrl_busy_o, 1'b1);
    step();

    // random forwarding and stall traffic in decode
    for (int i = 0; i < RAND_CYCLES; i++) begin
      rng_state          = xorshift32(rng_state);
      word               = rng_state;
      regfile_we_ex      = word[0];
      regfile_we_wb      = word[1];
      regfile_alu_we_fw  = word[2];
      reg_d_ex_is_reg_a  = word[3];
      reg_d_ex_is_reg_b  = word[4];
      reg_d_ex_is_reg_c  = word[5];
      reg_d_wb_is_reg_a  = word[6];
      reg_d_wb_is_reg_b  = word[7];
      reg_d_wb_is_reg_c  = word[8];
      reg_d_alu_is_reg_a = word[9];
      reg_d_alu_is_reg_b = word[10];
      reg_d_alu_is_reg_c = word[11];
      data_req_ex        = word[12];
      // misaligned is rare, one in four
      data_misaligned    = word[13] & word[14];
      mult_multicycle    = word[15];
      instr_valid        = word[16];
      jump_in_dec        = word[18:17];
      illegal_insn       = word[19] & word[20];
      #1;

      exp_a = fw_priority(regfile_we_wb & reg_d_wb_is_reg_a,
                          regfile_alu_we_fw & reg_d_alu_is_reg_a);
      exp_b = fw_priority(regfile_we_wb & reg_d_wb_is_reg_b,
                          regfile_alu_we_fw & reg_d_alu_is_reg_b);
      exp_c = fw_priority(regfile_we_wb & reg_d_wb_is_reg_c,
                          regfile_alu_we_fw & reg_d_alu_is_reg_c);
      if (data_misaligned) begin
        exp_a = SEL_FW_EX;
        exp_b = SEL_REGFILE;
      end else if (mult_multicycle) begin
        exp_c = SEL_FW_EX;
      end

      exp_load = data_req_ex & regfile_we_ex &
                 (reg_d_ex_is_reg_a | reg_d_ex_is_reg_b | reg_d_ex_is_reg_c);
      exp_jr   = (jump_in_dec == BRANCH_JALR) &
                 ((regfile_we_wb & reg_d_wb_is_reg_a) |
                  (regfile_we_ex & reg_d_ex_is_reg_a) |
                  (regfile_alu_we_fw & reg_d_alu_is_reg_a));
      // id is never stalled here, so no jump is marked done
      exp_jump = instr_valid & ~exp_jr &
                 ((jump_in_dec == BRANCH_JAL) | (jump_in_dec == BRANCH_JALR));

      expect_code("operand_a_fw_mux_sel_o", {1'b0, operand_a_fw_mux_sel_o}, {1'b0, exp_a});
      expect_code("operand_b_fw_mux_sel_o", {1'b0, operand_b_fw_mux_sel_o}, {1'b0, exp_b});
      expect_code("operand_c_fw_mux_sel_o", {1'b0, operand_c_fw_mux_sel_o}, {1'b0, exp_c});
      expect_bit("load_stall_o", load_stall_o, exp_load);
      expect_bit("jr_stall_o", jr_stall_o, exp_jr);
      expect_bit("is_decoding_o", is_decoding_o, instr_valid);
      expect_bit("deassert_we_o", deassert_we_o,
                 ~instr_valid | illegal_insn | exp_load | exp_jr);
      expect_bit("pc_set_o", pc_set_o, exp_jump);
      expect_bit("exc_restore_id_o", exc_restore_id_o, 1'b0);
      step();
    end

    // jal under back-pressure redirects fetch once
    quiet_pipeline();
    instr_valid = 1'b1;
    jump_in_dec = BRANCH_JAL;
    id_ready    = 1'b0;
    #1;
    expect_bit("pc_set_o", pc_set_o, 1'b1);
    expect_code("pc_mux_o", pc_mux_o, PC_JUMP);
    step();
    repeat (3) begin
      #1;
      expect_bit("pc_set_o", pc_set_o, 1'b0);
      step();
    end
    id_ready = 1'b1;
    #1;
    expect_bit("pc_set_o", pc_set_o, 1'b0);
    step();

    // jalr waits for the pending ex write to operand a
    jump_in_dec       = BRANCH_JALR;
    regfile_we_ex     = 1'b1;
    reg_d_ex_is_reg_a = 1'b1;
    id_ready          = 1'b0;
    repeat (3) begin
      #1;
      expect_bit("jr_stall_o", jr_stall_o, 1'b1);
      expect_bit("pc_set_o", pc_set_o, 1'b0);
      expect_bit("deassert_we_o", deassert_we_o, 1'b1);
      step();
    end
    regfile_we_ex = 1'b0;
    #1;
    expect_bit("jr_stall_o", jr_stall_o, 1'b0);
    expect_bit("pc_set_o", pc_set_o, 1'b1);
    expect_code("pc_mux_o", pc_mux_o, PC_JUMP);
    step();
    id_ready = 1'b1;
    #1;
    expect_bit("pc_set_o", pc_set_o, 1'b0);
    step();

    // taken branch, then branch with interrupt
    quiet_pipeline();
    instr_valid     = 1'b1;
    branch_taken_ex = 1'b1;
    #1;
    expect_bit("pc_set_o", pc_set_o, 1'b1);
    expect_code("pc_mux_o", pc_mux_o, PC_BRANCH);
    expect_bit("is_decoding_o", is_decoding_o, 1'b0);
    expect_bit("exc_ack_o", exc_ack_o, 1'b0);
    step();
    ext_req = 1'b1;
    #1;
    expect_bit("pc_set_o", pc_set_o, 1'b1);
    expect_code("pc_mux_o", pc_mux_o, PC_EXCEPTION);
    expect_bit("exc_ack_o", exc_ack_o, 1'b1);
    expect_bit("exc_save_takenbranch_o", exc_save_takenbranch_o, 1'b1);
    step();

    // exception on a plain instruction in decode
    quiet_pipeline();
    instr_valid = 1'b1;
    exc_req     = 1'b1;
    #1;
    expect_bit("pc_set_o", pc_set_o, 1'b1);
    expect_code("pc_mux_o", pc_mux_o, PC_EXCEPTION);
    expect_bit("exc_ack_o", exc_ack_o, 1'b1);
    expect_bit("exc_save_id_o", exc_save_id_o, 1'b1);
    expect_bit("halt_id_o", halt_id_o, 1'b1);
    step();

    // eret with fetch enabled restores the saved pc and keeps decoding
    quiet_pipeline();
    instr_valid = 1'b1;
    eret_insn   = 1'b1;
    #1;
    expect_bit("pc_set_o", pc_set_o, 1'b1);
    expect_code("pc_mux_o", pc_mux_o, PC_ERET);
    expect_bit("exc_restore_id_o", exc_restore_id_o, 1'b1);
    expect_bit("halt_if_o", halt_if_o, 1'b0);
    step();

    // flush with fetch disabled ends in sleep
    quiet_pipeline();
    instr_valid  = 1'b1;
    pipe_flush   = 1'b1;
    fetch_enable = 1'b0;
    #1;
    expect_bit("halt_if_o", halt_if_o, 1'b1);
    expect_bit("halt_id_o", halt_id_o, 1'b1);
    step();
    quiet_pipeline();
    repeat (2) begin
      #1;
      expect_bit("halt_if_o", halt_if_o, 1'b1);
      expect_bit("halt_id_o", halt_id_o, 1'b1);
      expect_bit("ctrl_busy_o", ctrl_busy_o, 1'b1);
      step();
    end
    ex_valid = 1'b1;
    step();
    ex_valid = 1'b0;
    wait_idle(4);
    expect_bit("instr_req_o", instr_req_o, 1'b0);
    step();

    // interrupt wakes the core, first fetch saves the if pc
    id_ready = 1'b0;
    exc_req  = 1'b1;
    #1;
    expect_bit("ctrl_busy_o", ctrl_busy_o, 1'b0);
    step();
    #1;
    expect_bit("ctrl_busy_o", ctrl_busy_o, 1'b1);
    expect_bit("pc_set_o", pc_set_o, 1'b1);
    expect_code("pc_mux_o", pc_mux_o, PC_EXCEPTION);
    expect_bit("exc_ack_o", exc_ack_o, 1'b1);
    expect_bit("exc_save_if_o", exc_save_if_o, 1'b1);
    step();
    exc_req = 1'b0;
    #1;
    expect_bit("exc_save_if_o", exc_save_if_o, 1'b0);
    expect_bit("ctrl_busy_o", ctrl_busy_o, 1'b1);
    step();

    $display("Everything OK");
    $finish;
  end

  // run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* sim.f */
logic/ctrl_pkg.sv
logic/fwd_select.sv
logic/hazard_detect.sv
logic/pipe_ctrl_fsm.sv
logic/core_controller.sv
tb/tb_clock_gen.sv
tb/tb_core_controller.sv

/* run.sh */
#!/bin/sh
# build and run the core controller testbench with verilator
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --timescale 1ns/1ns -f sim.f \
       --top-module tb_core_controller -o tb_sim \
  && ./obj_dir/tb_sim \
  || exit 1
